// File: build.f
+incdir+.
ntm_trainer_pkg.sv
ntm_lane_if.sv
ntm_step_scheduler.sv
ntm_gradient_lane.sv
ntm_gradient_collector.sv
ntm_trainer.sv
tb_ntm_trainer.sv

// File: Bender.yml
package:
  name: ntm_trainer

sources:
  - include_dirs:
      - .
    files:
      - ntm_trainer_pkg.sv
      - ntm_lane_if.sv
      - ntm_step_scheduler.sv
      - ntm_gradient_lane.sv
      - ntm_gradient_collector.sv
      - ntm_trainer.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_ntm_trainer.sv

// File: tb_ntm_trainer.sv
////////////////////////////////////////
// Testbench of the NTM trainer. Drives random
// runs from an xorshift source and checks
// the gradients against a reference model
////////////////////////////////////////

module tb_ntm_trainer
  import ntm_trainer_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period  = 40;
  localparam int drive_delay = 2;   // Inputs change after the edge
  localparam int max_len     = 16;
  localparam int max_gap     = 3;   // Idle cycles before a step
  localparam int n_b2b       = 12;  // Back-to-back runs
  localparam int n_gap       = 8;   // Runs with gaps
  localparam int n_stray     = 4;   // Runs with stray strobes
  localparam int ready_limit = 12;  // Cycles to wait for READY
  localparam int ready_lat   = 3;   // Edges from final step to READY
  localparam int total_steps = (n_b2b + n_gap + n_stray) * max_len + 1;
  localparam int total_runs  = n_b2b + n_gap + n_stray + 2;
  localparam int watchdog_cycles = total_steps * 4 + total_runs * 10 + 50;

  // DUT ports
  logic      CLK;
  logic      RST;
  logic      START;
  ntm_step_t LENGTH_IN;
  logic      IN_ENABLE;
  ntm_data_t D_IN;
  ntm_data_t X_IN;
  ntm_data_t R_IN;
  ntm_data_t H_IN;
  logic      READY;
  ntm_data_t W_OUT;
  ntm_data_t K_OUT;
  ntm_data_t U_OUT;
  ntm_data_t B_OUT;

  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          err_mark;

  // Reference model state
  ntm_data_t exp_w;
  ntm_data_t exp_k;
  ntm_data_t exp_u;
  ntm_data_t exp_b;
  ntm_data_t h_prev_m; // h(t-1) for dU
  logic      have_h;
  ntm_data_t held_w;   // Last published gradients
  ntm_data_t held_k;
  ntm_data_t held_u;
  ntm_data_t held_b;

  ntm_trainer UUT (
    .CLK       (CLK),
    .RST       (RST),
    .START     (START),
    .LENGTH_IN (LENGTH_IN),
    .IN_ENABLE (IN_ENABLE),
    .READY     (READY),
    .D_IN      (D_IN),
    .X_IN      (X_IN),
    .R_IN      (R_IN),
    .H_IN      (H_IN),
    .W_OUT     (W_OUT),
    .K_OUT     (K_OUT),
    .U_OUT     (U_OUT),
    .B_OUT     (B_OUT)
  );

  always #(clk_period / 2) CLK = ~CLK;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Xorshift32 step
  function automatic logic [31:0] next_rand();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  function automatic ntm_step_t rand_len();
    return ntm_step_t'((next_rand() % max_len) + 1);
  endfunction

  task automatic check_value(input string what, input ntm_data_t got, input ntm_data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Outputs must not move between READY pulses
  task automatic check_hold();
    if (READY !== 1'b1) begin
      check_value("W_OUT hold", W_OUT, held_w);
      check_value("K_OUT hold", K_OUT, held_k);
      check_value("U_OUT hold", U_OUT, held_u);
      check_value("B_OUT hold", B_OUT, held_b);
    end
  endtask

  // Next edge, then the drive point
  task automatic tick();
    @(posedge CLK);
    #drive_delay;
    check_hold();
  endtask

  task automatic model_step(input ntm_data_t d, input ntm_data_t x,
                            input ntm_data_t r, input ntm_data_t h);
    exp_w = exp_w + d * x;
    exp_k = exp_k + d * r;
    if (have_h)
      exp_u = exp_u + d * h_prev_m; // d(t) with h(t-1)
    exp_b = exp_b + d;
    h_prev_m = h;
    have_h   = 1'b1;
  endtask

  // Counts edges from the last sampled strobe to READY
  task automatic wait_ready(input bit strays);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < ready_limit) begin
      if (strays && cycles == 0) begin
        IN_ENABLE = 1'b1; // Lands in the flush cycle
        START     = 1'b1;
        D_IN      = next_rand();
        X_IN      = next_rand();
      end
      tick();
      IN_ENABLE = 1'b0;
      START     = 1'b0;
      cycles++;
      seen = (READY === 1'b1);
    end
    checks++;
    assert (seen) else begin
      errors++;
      $display("READY did not arrive within %0d cycles of the last strobe", ready_limit);
    end
    if (seen) begin
      assert (cycles == ready_lat) else begin
        errors++;
        $display("FAIL %0t ns: READY after %0d edges, expected %0d", $time, cycles, ready_lat);
      end
    end
  endtask

  // One training sequence of n steps
  task automatic do_run(input int n, input int gap_max, input bit strays);
    int        stray_at;
    int        gap;
    ntm_data_t d;
    ntm_data_t x;
    ntm_data_t r;
    ntm_data_t h;
    exp_w  = '0;
    exp_k  = '0;
    exp_u  = '0;
    exp_b  = '0;
    have_h = 1'b0;
    stray_at = (strays && n > 0) ? int'(next_rand() % n) : -1;
    START     = 1'b1;
    IN_ENABLE = strays; // Ignored while idle
    LENGTH_IN = ntm_step_t'(n);
    tick();
    START     = 1'b0;
    IN_ENABLE = 1'b0;
    LENGTH_IN = ntm_step_t'(next_rand()); // Not latched again
    for (int k = 0; k < n; k++) begin
      gap = (gap_max > 0) ? int'(next_rand() % (gap_max + 1)) : 0;
      repeat (gap) tick();
      d = next_rand();
      x = next_rand();
      r = next_rand();
      h = next_rand();
      IN_ENABLE = 1'b1;
      D_IN      = d;
      X_IN      = x;
      R_IN      = r;
      H_IN      = h;
      START     = (k == stray_at); // Ignored mid-run
      tick();
      IN_ENABLE = 1'b0;
      START     = 1'b0;
      model_step(d, x, r, h);
    end
    wait_ready(strays);
    check_value("W_OUT", W_OUT, exp_w);
    check_value("K_OUT", K_OUT, exp_k);
    check_value("U_OUT", U_OUT, exp_u);
    check_value("B_OUT", B_OUT, exp_b);
    held_w = exp_w;
    held_k = exp_k;
    held_u = exp_u;
    held_b = exp_b;
    tick();
    check_value("READY pulse width", ntm_data_t'(READY), '0); // One cycle only
  endtask

  task automatic report_test(input string name, input int mark);
    $display("Test %-30s %s", name, (errors == mark) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    CLK       = 1'b0;
    RST       = 1'b1;
    START     = 1'b0;
    LENGTH_IN = '0;
    IN_ENABLE = 1'b0;
    D_IN      = '0;
    X_IN      = '0;
    R_IN      = '0;
    H_IN      = '0;
    rng_state = 32'hf4fa_9eb8;
    errors    = 0;
    checks    = 0;
    held_w    = '0;
    held_k    = '0;
    held_u    = '0;
    held_b    = '0;
    repeat (2) @(posedge CLK);
    #drive_delay RST = 1'b0;

    err_mark = errors;
    tick();
    check_value("READY after reset", ntm_data_t'(READY), '0);
    check_value("W_OUT after reset", W_OUT, '0);
    check_value("K_OUT after reset", K_OUT, '0);
    check_value("U_OUT after reset", U_OUT, '0);
    check_value("B_OUT after reset", B_OUT, '0);
    report_test("reset state", err_mark);

    err_mark = errors;
    repeat (n_b2b) do_run(rand_len(), 0, 1'b0);
    report_test("back-to-back random runs", err_mark);

    err_mark = errors;
    repeat (n_gap) do_run(rand_len(), max_gap, 1'b0);
    report_test("runs with step gaps", err_mark);

    err_mark = errors;
    do_run(1, 0, 1'b0);
    check_value("U_OUT of length one", U_OUT, '0); // No h(t-1)
    do_run(0, 0, 1'b0);
    check_value("W_OUT of length zero", W_OUT, '0);
    check_value("K_OUT of length zero", K_OUT, '0);
    check_value("U_OUT of length zero", U_OUT, '0);
    check_value("B_OUT of length zero", B_OUT, '0);
    report_test("length one and zero", err_mark);

    err_mark = errors;
    repeat (n_stray) do_run(rand_len(), 2, 1'b1);
    report_test("stray START and IN_ENABLE", err_mark);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // Watchdog sized from the worst-case step count
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired after %0d cycles, the run is stuck", watchdog_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: ntm_trainer.sv
////////////////////////////////////////
// Training back end of the NTM controller
// Accumulates dW, dK, dU and db over one
// sequence and presents them with READY
////////////////////////////////////////

`include "ntm_trainer_consts.svh"

module ntm_trainer
  import ntm_trainer_pkg::*;
(
  // Global
  input  logic      CLK,
  input  logic      RST,

  // Control
  input  logic      START,     // One-cycle strobe
  input  ntm_step_t LENGTH_IN, // Sequence length T
  input  logic      IN_ENABLE, // One step per strobe
  output logic      READY,     // One-cycle pulse per run

  // Step operands
  input  ntm_data_t D_IN, // Error d(t)
  input  ntm_data_t X_IN, // Input x(t)
  input  ntm_data_t R_IN, // Read vector r(t)
  input  ntm_data_t H_IN, // Hidden state h(t)

  // Gradients
  output ntm_data_t W_OUT,
  output ntm_data_t K_OUT,
  output ntm_data_t U_OUT,
  output ntm_data_t B_OUT
);

  ////////////////////////////////////////
  // Lane bundles
  ////////////////////////////////////////

  // Indexed by ntm_grad_kind_t
  ntm_lane_if lane_bus [`NTM_LANES] ();

  // Scheduler
  ntm_step_scheduler u_sched (
    .CLK       (CLK),
    .RST       (RST),
    .START     (START),
    .LENGTH_IN (LENGTH_IN),
    .IN_ENABLE (IN_ENABLE),
    .D_IN      (D_IN),
    .X_IN      (X_IN),
    .R_IN      (R_IN),
    .H_IN      (H_IN),
    .lanes     (lane_bus)
  );

  ////////////////////////////////////////
  // Gradient lanes
  ////////////////////////////////////////

  for (genvar i = 0; i < `NTM_LANES; i++) begin : g_lane
    ntm_gradient_lane u_lane (
      .CLK (CLK),
      .RST (RST),
      .bus (lane_bus[i])
    );
  end

  // Collector
  ntm_gradient_collector u_collect (
    .CLK   (CLK),
    .RST   (RST),
    .lanes (lane_bus),
    .READY (READY),
    .W_OUT (W_OUT),
    .K_OUT (K_OUT),
    .U_OUT (U_OUT),
    .B_OUT (B_OUT)
  );

endmodule

// File: ntm_gradient_collector.sv
////////////////////////////////////////
// Gradient collector. Waits for every lane
// to finish, then registers the sums and
// pulses READY once per run
////////////////////////////////////////

`include "ntm_trainer_consts.svh"

module ntm_gradient_collector
  import ntm_trainer_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  ntm_lane_if.drain lanes [`NTM_LANES],
  output logic      READY, // One-cycle pulse
  output ntm_data_t W_OUT,
  output ntm_data_t K_OUT,
  output ntm_data_t U_OUT,
  output ntm_data_t B_OUT
);

  ntm_collect_state_t    state;
  logic [`NTM_LANES-1:0] done_v;
  logic [`NTM_LANES-1:0] clear_v;
  ntm_data_t             sum_v [`NTM_LANES];
  logic                  all_done;
  logic                  capture; // Take the result this cycle

  // Flatten the lane bundles
  for (genvar g = 0; g < `NTM_LANES; g++) begin : g_drain
    assign done_v[g]  = lanes[g].done;
    assign clear_v[g] = lanes[g].clear;
    assign sum_v[g]   = lanes[g].sum;
  end

  assign all_done = &done_v;
  assign capture  = (state == COLLECT_WAIT) && all_done;

  ////////////////////////////////////////
  // Collect FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= COLLECT_WAIT;
      READY <= 1'b0;
    end else begin
      READY <= capture;
      // A clear on the capture edge still re-arms for the next run
      if (|clear_v)
        state <= COLLECT_WAIT;
      else if (capture)
        state <= COLLECT_HOLD;
    end
  end

  // Result registers, held until the next capture
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      W_OUT <= '0;
      K_OUT <= '0;
      U_OUT <= '0;
      B_OUT <= '0;
    end else if (capture) begin
      W_OUT <= sum_v[GRAD_W];
      K_OUT <= sum_v[GRAD_K];
      U_OUT <= sum_v[GRAD_U];
      B_OUT <= sum_v[GRAD_B];
    end
  end

endmodule

// File: ntm_gradient_lane.sv
////////////////////////////////////////
// One gradient lane. Multiplies the fed
// pair and accumulates modulo 2^width
////////////////////////////////////////

`include "ntm_trainer_consts.svh"

module ntm_gradient_lane
  import ntm_trainer_pkg::*;
(
  input logic     CLK,
  input logic     RST,
  ntm_lane_if.lane bus
);

  ntm_data_t product; // Truncated to the data width
  ntm_data_t acc;
  logic      done_q;

  // Wrapped product of the step
  assign product = bus.err * bus.operand;

  ////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc    <= '0;
      done_q <= 1'b0;
    end else if (bus.clear) begin
      // New run
      acc    <= '0;
      done_q <= 1'b0;
    end else begin
      if (bus.step_en)
        acc <= acc + product; // Wraps on overflow
      if (bus.last)
        done_q <= 1'b1; // Sticky until next clear
    end
  end

  assign bus.sum  = acc;
  assign bus.done = done_q;

endmodule

// File: ntm_step_scheduler.sv
////////////////////////////////////////
// Step scheduler. Latches the run length,
// counts strobed steps and feeds the four
// gradient lanes through a capture stage
////////////////////////////////////////

`include "ntm_trainer_consts.svh"

module ntm_step_scheduler
  import ntm_trainer_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      START,     // Begins a run from idle
  input  ntm_step_t LENGTH_IN, // Steps in the run
  input  logic      IN_ENABLE, // One step strobe
  input  ntm_data_t D_IN,
  input  ntm_data_t X_IN,
  input  ntm_data_t R_IN,
  input  ntm_data_t H_IN,
  ntm_lane_if.feeder lanes [`NTM_LANES]
);

  ntm_sched_state_t state;
  ntm_step_t        len_q;    // Latched LENGTH_IN
  ntm_step_t        cnt;      // Steps accepted so far
  ntm_step_t        cnt_next;
  logic             run_start; // START taken this cycle
  logic             accept;    // IN_ENABLE taken this cycle

  // Capture stage
  logic      in_valid;
  ntm_data_t d_q;
  ntm_data_t x_q;
  ntm_data_t r_q;
  ntm_data_t h_q;

  // Feed stage, drives the lanes
  logic                  clear_q;
  logic                  last_q;
  logic [`NTM_LANES-1:0] step_en_q;
  logic                  h_valid; // h_prev holds a real step
  ntm_data_t             err_q;
  ntm_data_t             h_prev;  // h from the previous step
  ntm_data_t             operand_q [`NTM_LANES];

  assign cnt_next  = cnt + 1'b1;
  assign run_start = (state == SCHED_IDLE) && START;
  assign accept    = (state == SCHED_RUN) && IN_ENABLE;

  ////////////////////////////////////////
  // Run control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= SCHED_IDLE;
      len_q    <= '0;
      cnt      <= '0;
      in_valid <= 1'b0;
    end else begin
      in_valid <= accept;
      case (state)
        SCHED_IDLE: begin
          if (START) begin
            len_q <= LENGTH_IN;
            cnt   <= '0;
            // Empty run skips straight to the lone last strobe
            state <= (LENGTH_IN == '0) ? SCHED_FLUSH : SCHED_RUN;
          end
        end
        SCHED_RUN: begin
          if (IN_ENABLE) begin
            cnt <= cnt_next;
            if (cnt_next == len_q) state <= SCHED_FLUSH; // Final step
          end
        end
        SCHED_FLUSH: state <= SCHED_IDLE; // Capture stage empties here
        default:     state <= SCHED_IDLE;
      endcase
    end
  end

  // Step operands
  always_ff @(posedge CLK) begin
    if (accept) begin
      d_q <= D_IN;
      x_q <= X_IN;
      r_q <= R_IN;
      h_q <= H_IN;
    end
  end

  ////////////////////////////////////////
  // Lane feeds
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      clear_q   <= 1'b0;
      last_q    <= 1'b0;
      step_en_q <= '0;
      h_valid   <= 1'b0;
    end else begin
      clear_q           <= run_start;
      last_q            <= (state == SCHED_FLUSH); // With final step or alone
      step_en_q[GRAD_W] <= in_valid;
      step_en_q[GRAD_K] <= in_valid;
      step_en_q[GRAD_U] <= in_valid && h_valid; // No h(t-1) on first step
      step_en_q[GRAD_B] <= in_valid;
      if (run_start)
        h_valid <= 1'b0;
      else if (in_valid)
        h_valid <= 1'b1;
    end
  end

  // Operand pairing per gradient
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      err_q             <= d_q;
      operand_q[GRAD_W] <= x_q;
      operand_q[GRAD_K] <= r_q;
      operand_q[GRAD_U] <= h_prev;         // Pairs d(t) with h(t-1)
      operand_q[GRAD_B] <= ntm_data_t'(1); // Bias sums d alone
      h_prev            <= h_q;
    end
  end

  for (genvar g = 0; g < `NTM_LANES; g++) begin : g_feed
    assign lanes[g].clear   = clear_q;
    assign lanes[g].step_en = step_en_q[g];
    assign lanes[g].last    = last_q;
    assign lanes[g].err     = err_q;
    assign lanes[g].operand = operand_q[g];
  end

endmodule

// File: ntm_lane_if.sv
////////////////////////////////////////
// Feed and drain bundle of one gradient
// lane, scheduler to lane to collector
////////////////////////////////////////

interface ntm_lane_if
  import ntm_trainer_pkg::*;
();

  // Feed side, all single-cycle strobes
  logic      clear;   // Start of a run
  logic      step_en; // err * operand is valid
  logic      last;    // Final strobe of the run
  ntm_data_t err;     // Error term d
  ntm_data_t operand; // x, r, h(t-1) or one

  // Result side
  ntm_data_t sum;  // Running accumulation
  logic      done; // Level, held until next clear

  // Scheduler end
  modport feeder (output clear, step_en, last, err, operand);

  // Accumulator itself
  modport lane (input clear, step_en, last, err, operand, output sum, done);

  // Collector end, re-arms on clear
  modport drain (input sum, done, clear);

endinterface

// File: ntm_trainer_pkg.sv
////////////////////////////////////////
// Shared types of the NTM trainer
// Imported by every RTL block
////////////////////////////////////////

`include "ntm_trainer_consts.svh"

package ntm_trainer_pkg;

  // Wrapped value or running sum
  typedef logic [`NTM_DATA_WIDTH-1:0] ntm_data_t;

  // Sequence length or step index
  typedef logic [`NTM_STEP_WIDTH-1:0] ntm_step_t;

  // Gradient kind, doubles as lane index
  typedef enum logic [1:0] {
    GRAD_W = 2'd0, // d(t) * x(t)
    GRAD_K = 2'd1, // d(t) * r(t)
    GRAD_U = 2'd2, // d(t+1) * h(t)
    GRAD_B = 2'd3  // d(t) * 1
  } ntm_grad_kind_t;

  // Step scheduler FSM
  typedef enum logic [1:0] {
    SCHED_IDLE,
    SCHED_RUN,
    SCHED_FLUSH // Final step draining, or empty run
  } ntm_sched_state_t;

  // Collector FSM
  typedef enum logic {
    COLLECT_WAIT,
    COLLECT_HOLD // Result taken, waiting for next clear
  } ntm_collect_state_t;

endpackage

// File: ntm_trainer_consts.svh
////////////////////////////////////////
// Sizing macros for the NTM trainer
// Include ahead of the package and RTL
////////////////////////////////////////

`ifndef NTM_TRAINER_CONSTS_SVH
`define NTM_TRAINER_CONSTS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

`define NTM_DATA_WIDTH 32 // Values, products and sums
`define NTM_STEP_WIDTH 8  // Sequence length and step count

// One lane per gradient dW, dK, dU and db
`define NTM_LANES 4

`endif
